/* source/shift_macros.svh */
//******************************
// Shift unit build parameters
// Widths and extension enable
//******************************

`ifndef SHIFT_MACROS_SVH
`define SHIFT_MACROS_SVH

`define SHIFT_W_DATA 32   // Operand and result width

`define SHIFT_W_SHAMT 5   // log2 of data width

`define SHIFT_EXT_ZBB 1   // Rotates enabled when nonzero

`define SHIFT_W_TAG 4     // Request tag width

`endif

/* source/shift_op_pkg.sv */
//******************************
// Shift unit external types
// Request, response and op codes
//******************************

`include "shift_macros.svh"

package shift_op_pkg;

	// Codes 5 to 7 are undefined
	typedef enum logic [2:0] {
		OP_SLL = 3'd0, // Shift left logical
		OP_SRL = 3'd1, // Shift right logical
		OP_SRA = 3'd2, // Shift right arithmetic
		OP_ROL = 3'd3, // Rotate left
		OP_ROR = 3'd4  // Rotate right
	} shift_op_e;

	typedef struct packed {
		logic [`SHIFT_W_DATA-1:0]  operand; // Value to shift
		logic [`SHIFT_W_SHAMT-1:0] shamt;   // Shift amount
		shift_op_e                 op;      // Operation
		logic [`SHIFT_W_TAG-1:0]   tag;     // Echoed in response
	} shift_req_t;

	typedef struct packed {
		logic [`SHIFT_W_DATA-1:0] result;  // Shifted value
		logic [`SHIFT_W_TAG-1:0]  tag;     // From request
		logic                     illegal; // Op not supported
	} shift_resp_t;

endpackage

/* source/shift_pipe_pkg.sv */
//******************************
// Shift unit stage payloads
// Decoded barrel controls
//******************************

`include "shift_macros.svh"

package shift_pipe_pkg;

	// Carried from decode into the barrel stage
	typedef struct packed {
		logic [`SHIFT_W_DATA-1:0]  operand;     // Zero for illegal ops
		logic [`SHIFT_W_SHAMT-1:0] shamt;       // Shift amount
		logic                      right_nleft; // Right shift or rotate
		logic                      rotate;      // Wrap bits around
		logic                      arith;       // Sign fill
		logic [`SHIFT_W_TAG-1:0]   tag;         // Request tag
		logic                      illegal;     // Flag for response
	} shift_ctrl_t;

endpackage

/* source/shift_req_ingress.sv */
//******************************
// Shift request ingress
// Four-phase receiver with one
// entry buffer to valid/ready
//******************************

`timescale 1ns/1ps

`default_nettype none

module shift_req_ingress (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    req,
	input  shift_op_pkg::shift_req_t req_data,
	output logic                    ack,
	output logic                    out_valid,
	output shift_op_pkg::shift_req_t out_data,
	input  logic                    out_ready
);

	import shift_op_pkg::*;

	typedef enum logic {
		hs_idle,  // Waiting for req high
		hs_acked  // ack high, waiting for req low
	} hs_state_e;

	hs_state_e  hs_state;
	logic       buf_valid; // Buffer holds an item
	shift_req_t buf_data;
	logic       capture;

	assign capture = req && !buf_valid && (hs_state == hs_idle); // Take new request

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hs_state  <= hs_idle;
			buf_valid <= 1'b0;
		end else begin
			if (out_valid && out_ready) // Downstream took it
				buf_valid <= 1'b0;
			if (capture) begin
				buf_valid <= 1'b1;
				hs_state  <= hs_acked; // ack rises on capture edge
			end else if (hs_state == hs_acked && !req) begin
				hs_state  <= hs_idle; // Requester released
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture)
			buf_data <= req_data; // Latch request payload
	end

	assign ack       = (hs_state == hs_acked);
	assign out_valid = buf_valid;
	assign out_data  = buf_data;

endmodule

`default_nettype wire

/* source/shift_decode.sv */
//******************************
// Shift op decode
// Op code to barrel controls
//******************************

`timescale 1ns/1ps

`include "shift_macros.svh"

`default_nettype none

module shift_decode (
	input  logic                       in_valid,
	input  shift_op_pkg::shift_req_t   in_data,
	output logic                       in_ready,
	output logic                       out_valid,
	output shift_pipe_pkg::shift_ctrl_t out_data,
	input  logic                       out_ready
);

	import shift_op_pkg::*;
	import shift_pipe_pkg::*;

	localparam bit ext_zbb = (`SHIFT_EXT_ZBB != 0); // Rotates built in

	logic right_nleft;
	logic rotate;
	logic arith;
	logic illegal;

	always_comb begin
		right_nleft = 1'b0;
		rotate      = 1'b0;
		arith       = 1'b0;
		illegal     = 1'b0;
		case (in_data.op)
			OP_SLL: ;                                  // Plain left shift
			OP_SRL: right_nleft = 1'b1;
			OP_SRA: begin
				right_nleft = 1'b1;
				arith       = 1'b1;                    // Only SRA fills with sign
			end
			OP_ROL: begin
				rotate  = 1'b1;
				illegal = !ext_zbb;
			end
			OP_ROR: begin
				right_nleft = 1'b1;
				rotate      = 1'b1;
				illegal     = !ext_zbb;
			end
			default: illegal = 1'b1;                   // Undefined code
		endcase
	end

	assign out_data = '{
		operand:     illegal ? '0 : in_data.operand, // Zero result when illegal
		shamt:       in_data.shamt,
		right_nleft: right_nleft,
		rotate:      rotate,
		arith:       arith,
		tag:         in_data.tag,
		illegal:     illegal
	};

	assign out_valid = in_valid; // Combinational stage
	assign in_ready  = out_ready;

endmodule

`default_nettype wire

/* source/pipe_stage_reg.sv */
//******************************
// Pipeline stage register
// One entry valid/ready slot
//******************************

`timescale 1ns/1ps

`default_nettype none

module pipe_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     in_ready,
	output logic     out_valid,
	output payload_t out_data,
	input  logic     out_ready
);

	logic     full;     // Slot occupied
	payload_t data_q;

	// Free now or draining this cycle
	assign in_ready = !full || out_ready;

	always_ff @(posedge clk) begin
		if (!rst_n)
			full <= 1'b0;
		else if (in_ready)
			full <= in_valid; // Refill or go empty
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready)
			data_q <= in_data;
	end

	assign out_valid = full;
	assign out_data  = data_q;

endmodule

`default_nettype wire

/* source/shift_barrel.sv */
//******************************
// Shift barrel
// Log shifter with bit reversal
// for right shifts and rotates
//******************************

`timescale 1ns/1ps

`include "shift_macros.svh"

`default_nettype none

module shift_barrel (
	input  logic                       in_valid,
	input  shift_pipe_pkg::shift_ctrl_t in_data,
	output logic                       in_ready,
	output logic                       out_valid,
	output shift_op_pkg::shift_resp_t  out_data,
	input  logic                       out_ready
);

	import shift_op_pkg::*;
	import shift_pipe_pkg::*;

	localparam int w_data  = `SHIFT_W_DATA;
	localparam int w_shamt = `SHIFT_W_SHAMT;

	logic [w_data-1:0] din_rev;   // Operand in left-shift order
	logic [w_data-1:0] accum;     // Running layer result
	logic [w_data-1:0] shifted;   // Back in natural order
	logic              sign_fill; // Ones shifted in for SRA

	assign sign_fill = in_data.arith && in_data.operand[w_data-1];

	always_comb begin
		for (int i = 0; i < w_data; i++)
			din_rev[i] = in_data.right_nleft ? in_data.operand[w_data-1-i] : in_data.operand[i];

		accum = din_rev;
		// One layer per shamt bit, each a shift by a power of two
		for (int k = 0; k < w_shamt; k++) begin
			if (in_data.shamt[k]) begin
				accum = (accum << (1 << k))
					| ({w_data{sign_fill}} & ~({w_data{1'b1}} << (1 << k)))       // Sign bits
					| ({w_data{in_data.rotate}} & (accum >> (w_data - (1 << k)))); // Wrap
			end
		end

		for (int i = 0; i < w_data; i++)
			shifted[i] = in_data.right_nleft ? accum[w_data-1-i] : accum[i];
	end

	assign out_data = '{
		result:  shifted,
		tag:     in_data.tag,
		illegal: in_data.illegal
	};

	assign out_valid = in_valid; // Handshake passes straight through
	assign in_ready  = out_ready;

endmodule

`default_nettype wire

/* source/shift_resp_egress.sv */
//******************************
// Shift response egress
// Four-phase sender holding
// one result until released
//******************************

`timescale 1ns/1ps

`default_nettype none

module shift_resp_egress (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid,
	input  shift_op_pkg::shift_resp_t in_data,
	output logic                     in_ready,
	output logic                     resp_req,
	output shift_op_pkg::shift_resp_t resp_data,
	input  logic                     resp_ack
);

	import shift_op_pkg::*;

	typedef enum logic [1:0] {
		eg_idle,    // Empty, accepting
		eg_req,     // resp_req high, waiting for ack
		eg_release  // resp_req low, waiting for ack low
	} eg_state_e;

	eg_state_e   eg_state;
	shift_resp_t data_q;
	logic        load;

	assign in_ready = (eg_state == eg_idle);
	assign load     = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			eg_state <= eg_idle;
		end else begin
			case (eg_state)
				eg_idle:    if (load) eg_state <= eg_req;           // resp_req rises
				eg_req:     if (resp_ack) eg_state <= eg_release;   // resp_req falls
				eg_release: if (!resp_ack) eg_state <= eg_idle;     // Ready next cycle
				default:    eg_state <= eg_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load)
			data_q <= in_data; // Stable until the next load
	end

	assign resp_req  = (eg_state == eg_req);
	assign resp_data = data_q;

endmodule

`default_nettype wire

/* source/shift_unit_top.sv */
//******************************
// Shift execution unit
// Ingress, decode, barrel and
// egress with stage registers
//******************************

`timescale 1ns/1ps

`default_nettype none

module shift_unit_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     req,
	input  shift_op_pkg::shift_req_t  req_data,
	output logic                     ack,
	output logic                     resp_req,
	output shift_op_pkg::shift_resp_t resp_data,
	input  logic                     resp_ack
);

	import shift_op_pkg::*;
	import shift_pipe_pkg::*;

	logic        ing_valid, ing_ready;  // Ingress to decode
	shift_req_t  ing_data;
	logic        dec_valid, dec_ready;  // Decode to stage 1
	shift_ctrl_t dec_data;
	logic        ctl_valid, ctl_ready;  // Stage 1 to barrel
	shift_ctrl_t ctl_data;
	logic        bar_valid, bar_ready;  // Barrel to stage 2
	shift_resp_t bar_data;
	logic        res_valid, res_ready;  // Stage 2 to egress
	shift_resp_t res_data;

	shift_req_ingress ingress0 (
		.clk(clk), .rst_n(rst_n), .req(req), .req_data(req_data), .ack(ack),
		.out_valid(ing_valid), .out_data(ing_data), .out_ready(ing_ready)
	);

	shift_decode decode0 (
		.in_valid(ing_valid), .in_data(ing_data), .in_ready(ing_ready),
		.out_valid(dec_valid), .out_data(dec_data), .out_ready(dec_ready)
	);

	pipe_stage_reg #(.payload_t(shift_ctrl_t)) stage_ctrl0 (
		.clk(clk), .rst_n(rst_n),
		.in_valid(dec_valid), .in_data(dec_data), .in_ready(dec_ready),
		.out_valid(ctl_valid), .out_data(ctl_data), .out_ready(ctl_ready)
	);

	shift_barrel barrel0 (
		.in_valid(ctl_valid), .in_data(ctl_data), .in_ready(ctl_ready),
		.out_valid(bar_valid), .out_data(bar_data), .out_ready(bar_ready)
	);

	pipe_stage_reg #(.payload_t(shift_resp_t)) stage_resp0 (
		.clk(clk), .rst_n(rst_n),
		.in_valid(bar_valid), .in_data(bar_data), .in_ready(bar_ready),
		.out_valid(res_valid), .out_data(res_data), .out_ready(res_ready)
	);

	shift_resp_egress egress0 (
		.clk(clk), .rst_n(rst_n),
		.in_valid(res_valid), .in_data(res_data), .in_ready(res_ready),
		.resp_req(resp_req), .resp_data(resp_data), .resp_ack(resp_ack)
	);

endmodule

`default_nettype wire

/* testbench/tb_shift_unit.sv */
//******************************
// Shift unit testbench
// LFSR requests, reference model
// and handshake assertions
//******************************

`timescale 1ns/1ps

`include "shift_macros.svh"

module tb_shift_unit;

	import shift_op_pkg::*;

	localparam int w_data      = `SHIFT_W_DATA;
	localparam int w_shamt     = `SHIFT_W_SHAMT;
	localparam int timeout_cyc = 200;   // Cycles allowed per wait
	localparam int max_cyc     = 20000; // Whole run limit

	logic        clk;
	logic        rst_n;
	logic        req;
	shift_req_t  req_data;
	logic        ack;
	logic        resp_req;
	shift_resp_t resp_data;
	logic        resp_ack;

	logic [31:0]             lfsr;     // Galois LFSR state
	logic [`SHIFT_W_TAG-1:0] tag_ctr;
	shift_resp_t             exp_q[$]; // Expected results in issue order
	int          errors;
	int          proto_errors;         // Handshake assertion failures
	int          tests_passed;
	int          tests_failed;
	int          test_start_errs;
	bit          lat_check;            // Pipeline empty at each request
	bit          run_done;
	int          cyc;
	logic        ack_d;
	logic        resp_req_d;
	int          n_acked;              // Requests taken by the DUT
	int          n_launched;           // Responses started by the DUT
	bit          full_stall_seen;      // Buffer and both stages were full

	shift_unit_top dut0 (
		.clk(clk), .rst_n(rst_n), .req(req), .req_data(req_data), .ack(ack),
		.resp_req(resp_req), .resp_data(resp_data), .resp_ack(resp_ack)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk; // 20 ns period

	always @(posedge clk) begin
		cyc        <= cyc + 1;
		ack_d      <= ack;
		resp_req_d <= resp_req;
		if (!rst_n) begin
			n_acked         <= 0;
			n_launched      <= 0;
			full_stall_seen <= 1'b0;
		end else begin
			if (ack && !ack_d)
				n_acked <= n_acked + 1;
			if (resp_req && !resp_req_d)
				n_launched <= n_launched + 1;
			if ((n_acked - n_launched) == 3 && req && !ack)
				full_stall_seen <= 1'b1; // Requester held off
		end
	end

	assert property (@(posedge clk) $rose(rst_n) |-> (!ack && !resp_req))
		else begin
			$display("ack or resp_req high after reset at %0t", $time);
			proto_errors++;
		end
	assert property (@(posedge clk) disable iff (!rst_n) $fell(ack) |-> !$past(req))
		else begin
			$display("ack fell while req was still high at %0t", $time);
			proto_errors++;
		end
	assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(req))
		else begin
			$display("ack rose without a pending req at %0t", $time);
			proto_errors++;
		end
	assert property (@(posedge clk) disable iff (!rst_n) $fell(resp_req) |-> $past(resp_ack))
		else begin
			$display("resp_req fell before resp_ack rose at %0t", $time);
			proto_errors++;
		end
	assert property (@(posedge clk) disable iff (!rst_n)
		(resp_req && $past(resp_req)) |-> $stable(resp_data))
		else begin
			$display("resp_data changed while resp_req was high at %0t", $time);
			proto_errors++;
		end
	assert property (@(posedge clk) disable iff (!rst_n) (n_acked - n_launched) <= 3)
		else begin
			$display("More than three requests queued behind the egress at %0t", $time);
			proto_errors++;
		end
	assert property (@(posedge clk) disable iff (!rst_n)
		(lat_check && $rose(resp_req)) |-> ($past(ack, 3) && !$past(ack, 4)))
		else begin
			$display("resp_req did not rise 3 cycles after ack at %0t", $time);
			errors++;
		end

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic shift_req_t make_req(input logic [31:0] code, input logic [31:0] opnd,
		input logic [31:0] sh);
		shift_req_t r;
		r.operand = opnd;
		r.shamt   = sh[w_shamt-1:0];
		r.op      = shift_op_e'(code[2:0]);
		r.tag     = tag_ctr;
		tag_ctr   = tag_ctr + 1'b1; // Fresh tag per request
		return r;
	endfunction

	// Expected response from the instruction semantics
	function automatic shift_resp_t model(input shift_req_t r);
		shift_resp_t       e;
		logic [w_data-1:0] a;
		int                s;
		a         = r.operand;
		s         = int'(r.shamt);
		e.result  = '0;
		e.tag     = r.tag;
		e.illegal = 1'b0;
		case (r.op)
			OP_SLL:  e.result = a << s;
			OP_SRL:  e.result = a >> s;
			OP_SRA:  e.result = w_data'($signed(a) >>> s); // Ones in from a negative operand
			OP_ROL:  e.result = (a << s) | (a >> (w_data - s));
			OP_ROR:  e.result = (a >> s) | (a << (w_data - s));
			default: e.illegal = 1'b1;
		endcase
		if (`SHIFT_EXT_ZBB == 0 && (r.op == OP_ROL || r.op == OP_ROR)) begin
			e.result  = '0; // Rotates not built
			e.illegal = 1'b1;
		end
		return e;
	endfunction

	task automatic abort_run(input string what);
		$display("Timeout at %0t: %s within %0d cycles", $time, what, timeout_cyc);
		errors++;
		run_done = 1'b1;
		forever @(posedge clk); // Verdict block ends the run
	endtask

	task automatic wait_until(input bit on_resp, input logic level, input string what);
		int n;
		n = 0;
		while ((on_resp ? resp_req : ack) !== level) begin
			if (n == timeout_cyc)
				abort_run(what);
			@(posedge clk);
			#1;
			n++;
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic send_req(input shift_req_t r);
		@(posedge clk);
		#1;
		req_data = r;
		req      = 1'b1;
		exp_q.push_back(model(r));
		wait_until(1'b0, 1'b1, "ack did not rise");
		req = 1'b0;
		wait_until(1'b0, 1'b0, "ack did not fall");
	endtask

	task automatic recv_resp(input int delay);
		shift_resp_t exp;
		wait_until(1'b1, 1'b1, "resp_req did not rise");
		repeat (delay) begin
			@(posedge clk);
			#1;
		end
		if (exp_q.size() == 0) begin
			$display("Response at %0t with no request outstanding", $time);
			errors++;
		end else begin
			exp = exp_q.pop_front();
			check_value("resp_data.result", resp_data.result, exp.result);
			check_value("resp_data.tag", 32'(resp_data.tag), 32'(exp.tag));
			check_value("resp_data.illegal", 32'(resp_data.illegal), 32'(exp.illegal));
		end
		resp_ack = 1'b1;
		wait_until(1'b1, 1'b0, "resp_req did not fall");
		resp_ack = 1'b0;
	endtask

	task automatic transact(input shift_req_t r, input int delay);
		fork
			send_req(r);
			recv_resp(delay);
		join
	endtask

	task automatic finish_test(input string name, input int errs);
		if (errs == 0) begin
			tests_passed++;
			$display("%0t test %s: ok", $time, name);
		end else begin
			tests_failed++;
			$display("%0t test %s: %0d errors", $time, name, errs);
		end
	endtask

	task automatic run_tests();
		shift_req_t  reqs[8];
		int          dlys[8];
		logic [31:0] code;
		logic [31:0] opnd;
		logic [31:0] sh;
		int          dly;
		test_start_errs = errors;
		for (int i = 0; i < 12; i++) begin
			code = 32'(i % 3);                      // SLL, SRL and SRA in turn
			opnd = rand_bits(w_data);
			sh   = rand_bits(w_shamt);
			dly  = int'(rand_bits(3));
			if (code == 32'(OP_SRA) && i[0])
				opnd[w_data-1] = 1'b1;              // Negative under SRA
			transact(make_req(code, opnd, sh), dly);
		end
		finish_test("logical and arithmetic shifts", errors - test_start_errs);
		test_start_errs = errors;
		for (int i = 0; i < 10; i++) begin
			code = (i < 4) ? ((i < 2) ? 32'(OP_ROL) : 32'(OP_ROR)) : 32'(OP_ROL) + rand_bits(1);
			opnd = rand_bits(w_data);
			sh   = (i < 4) ? ((i % 2 == 1) ? 32'(w_data - 1) : 32'd0) // Edge amounts
				: rand_bits(w_shamt);
			dly  = int'(rand_bits(3));
			transact(make_req(code, opnd, sh), dly);
		end
		finish_test("rotates", errors - test_start_errs);
		test_start_errs = errors;
		for (int i = 0; i < 6; i++) begin
			code = 32'd5 + 32'(i % 3);              // Undefined codes
			opnd = rand_bits(w_data);
			sh   = rand_bits(w_shamt);
			dly  = int'(rand_bits(3));
			transact(make_req(code, opnd, sh), dly);
		end
		finish_test("illegal operations", errors - test_start_errs);
		test_start_errs = errors;
		lat_check       = 1'b0;                      // Requests overlap here
		for (int i = 0; i < 8; i++) begin
			code    = rand_bits(3) % 5;
			opnd    = rand_bits(w_data);
			sh      = rand_bits(w_shamt);
			reqs[i] = make_req(code, opnd, sh);
			dlys[i] = 8 + int'(rand_bits(3));        // Slow responder
		end
		fork
			for (int i = 0; i < 8; i++) send_req(reqs[i]);
			for (int i = 0; i < 8; i++) recv_resp(dlys[i]);
		join
		assert (full_stall_seen) else begin
			$display("Back-pressure never filled the buffer and both stage registers");
			errors++;
		end
		lat_check = 1'b1;
		finish_test("ordering under back-pressure", errors - test_start_errs);
		test_start_errs = errors;
		for (int i = 0; i < 6; i++) begin
			code = rand_bits(3) % 5;
			opnd = rand_bits(w_data);
			sh   = rand_bits(w_shamt);
			transact(make_req(code, opnd, sh), 0); // resp_ack at once
		end
		finish_test("unstalled latency", errors - test_start_errs);
	endtask

	initial begin : stimulus
		lfsr      = 32'd71;
		tag_ctr   = '0;
		rst_n     = 1'b0;
		req       = 1'b0;
		req_data  = '0;
		resp_ack  = 1'b0;
		lat_check = 1'b1;
		run_done  = 1'b0;
		repeat (4) @(posedge clk); // Reset for 4 cycles
		#1;
		rst_n = 1'b1;
		run_tests();
		run_done = 1'b1;
	end

	initial begin : verdict
		while (!run_done && cyc < max_cyc)
			@(posedge clk);
		if (!run_done) begin
			$display("Run did not complete within %0d cycles", max_cyc);
			errors++;
		end
		finish_test("handshake protocol", proto_errors);
		$display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0 && proto_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* sim.f */
+incdir+source
source/shift_op_pkg.sv
source/shift_pipe_pkg.sv
source/shift_req_ingress.sv
source/shift_decode.sv
source/pipe_stage_reg.sv
source/shift_barrel.sv
source/shift_resp_egress.sv
source/shift_unit_top.sv
testbench/tb_shift_unit.sv

/* Makefile */
# Verilator build and run for the shift unit testbench

VERILATOR ?= verilator
TOP       ?= tb_shift_unit
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
